//--- Makefile
SRCS := $(shell grep -v '^+' flist.f)

obj_dir/Vcpu_tb: flist.f $(SRCS)
	verilator --binary --assert -j 0 --top-module cpu_tb -f flist.f -o Vcpu_tb

run: obj_dir/Vcpu_tb
	obj_dir/Vcpu_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "Test passed" sim.log
	! grep -q "Test failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- flist.f
logic/cpu_pkg.sv
logic/cpu_alu.sv
logic/register_file.sv
logic/cpu_sequencer.sv
logic/cpu_top.sv
testbench/cpu_props.sv
testbench/cpu_tb.sv

//--- logic/cpu_alu.sv
module cpu_alu (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [3:0]  func,
  output logic [31:0] y,
  output logic        c,
  output logic        n,
  output logic        v,
  output logic        z
);

  logic [32:0] sum;
  logic [32:0] diff;
  logic [4:0]  shamt;

  assign sum   = {1'b0, a} + {1'b0, b};
  assign diff  = {1'b0, a} - {1'b0, b}; // bit 32 is the borrow
  assign shamt = b[4:0];

  always_comb begin
    c = 1'b0;
    v = 1'b0;
    case (func)
      cpu_pkg::ALU_AND: y = a & b;
      cpu_pkg::ALU_OR:  y = a | b;
      cpu_pkg::ALU_ADD: begin
        y = sum[31:0];
        c = sum[32];
        v = (a[31] == b[31]) && (sum[31] != a[31]);
      end
      cpu_pkg::ALU_SUB: begin
        y = diff[31:0];
        c = diff[32];
        v = (a[31] != b[31]) && (diff[31] != a[31]);
      end
      cpu_pkg::ALU_XOR: y = a ^ b;
      cpu_pkg::ALU_SHL: y = a << shamt;
      cpu_pkg::ALU_SHR: y = a >> shamt;
      cpu_pkg::ALU_SAR: y = $signed(a) >>> shamt;
      default:          y = 32'h00000000;
    endcase
  end

  assign n = y[31];
  assign z = (y == 32'h00000000);

endmodule

//--- logic/cpu_pkg.sv
package cpu_pkg;

  // modes 0..4, 8-bit opcode split over both instruction words
  typedef struct packed {
    logic [2:0] mode;
    logic [2:0] op_hi;
    logic [4:0] rb;
    logic [4:0] ra;
    logic [4:0] op_lo;
    logic [5:0] pad;
    logic [4:0] rc;
  } reg_form_t;

  // modes 5..7, opcode whole in the first word
  typedef struct packed {
    logic [2:0]  mode;
    logic [7:0]  op8;
    logic [4:0]  ra;
    logic [15:0] ext;
  } ext_form_t;

  typedef union packed {
    reg_form_t reg_form;
    ext_form_t ext_form;
  } instr_t;

  localparam logic [2:0] MODE_INH2   = 3'h0;
  localparam logic [2:0] MODE_IMM3   = 3'h1;
  localparam logic [2:0] MODE_REGIND = 3'h2;
  localparam logic [2:0] MODE_REG    = 3'h3;
  localparam logic [2:0] MODE_INH    = 3'h4;
  localparam logic [2:0] MODE_IMM2   = 3'h5;
  localparam logic [2:0] MODE_DIR    = 3'h6;
  localparam logic [2:0] MODE_IMM3A  = 3'h7;

  localparam logic [7:0] OP_NOP  = 8'h00;
  localparam logic [7:0] OP_CMP  = 8'h40;
  localparam logic [7:0] OP_INC  = 8'h60;
  localparam logic [7:0] OP_DEC  = 8'h80;
  localparam logic [7:0] OP_MOV  = 8'he0;
  localparam logic [7:0] OP_COM  = 8'h02;
  localparam logic [7:0] OP_NEG  = 8'h22;
  localparam logic [7:0] OP_LDIS = 8'h10;
  localparam logic [7:0] OP_LDIU = 8'h11;
  localparam logic [7:0] OP_BRA  = 8'h00;
  localparam logic [7:0] OP_BEQ  = 8'h01;
  localparam logic [7:0] OP_BNE  = 8'h02;
  localparam logic [7:0] OP_BGTU = 8'h03;
  localparam logic [7:0] OP_BGT  = 8'h04;
  localparam logic [7:0] OP_BGE  = 8'h05;
  localparam logic [7:0] OP_BLE  = 8'h06;
  localparam logic [7:0] OP_BLT  = 8'h07;
  localparam logic [7:0] OP_BGEU = 8'h08;
  localparam logic [7:0] OP_BLTU = 8'h09;
  localparam logic [7:0] OP_BLEU = 8'h0a;
  localparam logic [7:0] OP_BRN  = 8'h0b;
  localparam logic [7:0] OP_ST   = 8'h02;
  localparam logic [7:0] OP_LD   = 8'h03;
  localparam logic [7:0] OP_STD  = 8'h02;
  localparam logic [7:0] OP_LDD  = 8'h03;
  localparam logic [7:0] OP_JMPD = 8'h80;
  localparam logic [7:0] OP_LDI  = 8'h00;
  localparam logic [3:0] OP_ALU_GROUP = 4'h0; // upper nibble of alu opcodes

  localparam logic [3:0] ALU_AND = 4'h0;
  localparam logic [3:0] ALU_OR  = 4'h1;
  localparam logic [3:0] ALU_ADD = 4'h2;
  localparam logic [3:0] ALU_SUB = 4'h3;
  localparam logic [3:0] ALU_XOR = 4'h4;
  localparam logic [3:0] ALU_SHL = 4'h5;
  localparam logic [3:0] ALU_SHR = 4'h6;
  localparam logic [3:0] ALU_SAR = 4'h7;

  localparam logic [3:0] S_FETCH1 = 4'h0;
  localparam logic [3:0] S_EVAL1  = 4'h1;
  localparam logic [3:0] S_FETCH2 = 4'h2;
  localparam logic [3:0] S_EVAL2  = 4'h3;
  localparam logic [3:0] S_FETCH3 = 4'h4;
  localparam logic [3:0] S_EVAL3  = 4'h5;
  localparam logic [3:0] S_STORE  = 4'h6;
  localparam logic [3:0] S_LOAD   = 4'h7;
  localparam logic [3:0] S_LOAD2  = 4'h8;
  localparam logic [3:0] S_FAULT  = 4'h9;

  localparam logic [31:0] RESET_PC    = 32'hffc00000; // monitor base
  localparam logic [2:0]  FETCH_DELAY = 3'd3;
  localparam int          REG_ADDR_W  = 5;

endpackage

//--- logic/cpu_sequencer.sv
module cpu_sequencer (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] data_in,
  output logic [31:0] addrbus,
  output logic [15:0] data_out,
  output logic        write_out,
  output logic [3:0]  ccr,
  output logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr1,
  output logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr2,
  input  logic [31:0] rd_data1,
  input  logic [31:0] rd_data2,
  output logic        wr_en,
  output logic [cpu_pkg::REG_ADDR_W-1:0] wr_addr,
  output logic [31:0] wr_data,
  output logic [31:0] alu_a,
  output logic [31:0] alu_b,
  output logic [3:0]  alu_func,
  input  logic [31:0] alu_y,
  input  logic        alu_c,
  input  logic        alu_n,
  input  logic        alu_v,
  input  logic        alu_z
);

  logic [31:0]     pc, pc_next;
  logic [31:0]     mar, mar_next;
  logic [31:0]     mdr, mdr_next;
  cpu_pkg::instr_t ir, ir_next;
  logic [3:0]      state, state_next;
  logic [3:0]      ccr_next;
  logic [2:0]      delay, delay_next;
  logic            use_mar, use_mar_next;
  logic            write_out_next;

  logic [2:0]  ir_mode;
  logic [7:0]  ir_op;
  logic [4:0]  ir_ra;
  logic [31:0] imm_sext;
  logic        flag_c, flag_n, flag_v, flag_z;
  logic        taken;

  assign addrbus  = use_mar ? mar : pc;
  assign data_out = mdr[15:0];
  assign {flag_c, flag_n, flag_v, flag_z} = ccr;

  assign ir_mode  = ir.reg_form.mode;
  assign ir_op    = (ir_mode >= cpu_pkg::MODE_IMM2) ? ir.ext_form.op8
                                                    : {ir.reg_form.op_hi, ir.reg_form.op_lo};
  assign ir_ra    = (ir_mode >= cpu_pkg::MODE_IMM2) ? ir.ext_form.ra : ir.reg_form.ra;
  assign imm_sext = {{16{ir.ext_form.ext[15]}}, ir.ext_form.ext};

  always_comb begin
    case (ir_op)
      cpu_pkg::OP_BRA:  taken = 1'b1;
      cpu_pkg::OP_BEQ:  taken = flag_z;
      cpu_pkg::OP_BNE:  taken = ~flag_z;
      cpu_pkg::OP_BGTU: taken = ~(flag_z | flag_c);
      cpu_pkg::OP_BGT:  taken = ~(flag_z | (flag_n ^ flag_v));
      cpu_pkg::OP_BGE:  taken = ~(flag_n ^ flag_v);
      cpu_pkg::OP_BLE:  taken = flag_z | (flag_n ^ flag_v);
      cpu_pkg::OP_BLT:  taken = flag_n ^ flag_v;
      cpu_pkg::OP_BGEU: taken = ~flag_c;
      cpu_pkg::OP_BLTU: taken = flag_c;
      cpu_pkg::OP_BLEU: taken = flag_c | flag_z;
      cpu_pkg::OP_BRN:  taken = 1'b0;
      default:          taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc        <= cpu_pkg::RESET_PC;
      state     <= cpu_pkg::S_FETCH1;
      ccr       <= 4'h0;
      delay     <= 3'd0;
      use_mar   <= 1'b0;
      write_out <= 1'b0;
    end else begin
      pc        <= pc_next;
      state     <= state_next;
      ccr       <= ccr_next;
      delay     <= delay_next;
      use_mar   <= use_mar_next;
      write_out <= write_out_next;
    end
  end

  always_ff @(posedge clk) begin
    ir  <= ir_next;
    mar <= mar_next;
    mdr <= mdr_next;
  end

  always_comb begin
    pc_next        = pc;
    state_next     = state;
    ccr_next       = ccr;
    delay_next     = delay;
    use_mar_next   = use_mar;
    write_out_next = write_out;
    ir_next        = ir;
    mar_next       = mar;
    mdr_next       = mdr;
    rd_addr1       = ir.reg_form.rb;
    rd_addr2       = ir.reg_form.rc;
    wr_en          = 1'b0;
    wr_addr        = ir_ra;
    wr_data        = alu_y;
    alu_a          = rd_data1;
    alu_b          = rd_data2;
    alu_func       = cpu_pkg::ALU_ADD;
    case (state)
      cpu_pkg::S_FETCH1, cpu_pkg::S_FETCH2, cpu_pkg::S_FETCH3: begin
        if (delay == 3'd0) begin
          delay_next = cpu_pkg::FETCH_DELAY;
        end else begin
          delay_next = delay - 3'd1;
          if (delay == 3'd1) begin // word valid on this edge
            pc_next = pc + 32'd2;
            if (state == cpu_pkg::S_FETCH1) begin
              ir_next    = {data_in, 16'h0000};
              state_next = cpu_pkg::S_EVAL1;
            end else if (state == cpu_pkg::S_FETCH2) begin
              ir_next.ext_form.ext = data_in;
              mar_next   = {{21{data_in[10]}}, data_in[10:0]}; // regind offset
              state_next = cpu_pkg::S_EVAL2;
            end else begin
              if (ir_mode == cpu_pkg::MODE_DIR)
                mar_next = {ir.ext_form.ext, data_in};
              else if (ir_mode == cpu_pkg::MODE_IMM3A)
                mdr_next = {ir.ext_form.ext, data_in};
              else
                mdr_next = {{16{data_in[15]}}, data_in};
              state_next = cpu_pkg::S_EVAL3;
            end
          end
        end
      end
      cpu_pkg::S_EVAL1: begin
        rd_addr1   = ir_ra;
        rd_addr2   = ir.reg_form.rb;
        state_next = cpu_pkg::S_FETCH1;
        if (ir_mode != cpu_pkg::MODE_INH) begin
          state_next = cpu_pkg::S_FETCH2;
        end else begin
          case (ir_op)
            cpu_pkg::OP_NOP: ;
            cpu_pkg::OP_CMP: begin // ra - rb, three cycles
              alu_func = cpu_pkg::ALU_SUB;
              if (delay == 3'd0) begin
                delay_next = 3'd2;
                state_next = cpu_pkg::S_EVAL1;
              end else begin
                delay_next = delay - 3'd1;
                if (delay == 3'd1)
                  ccr_next = {alu_c, alu_n, alu_v, alu_z};
                else
                  state_next = cpu_pkg::S_EVAL1;
              end
            end
            cpu_pkg::OP_INC, cpu_pkg::OP_DEC: begin
              alu_b    = 32'd1;
              alu_func = (ir_op == cpu_pkg::OP_INC) ? cpu_pkg::ALU_ADD : cpu_pkg::ALU_SUB;
              wr_en    = 1'b1;
            end
            cpu_pkg::OP_MOV: begin
              rd_addr1 = ir.reg_form.rb;
              wr_data  = rd_data1;
              wr_en    = 1'b1;
            end
            default: state_next = cpu_pkg::S_FAULT;
          endcase
        end
      end
      cpu_pkg::S_EVAL2: begin
        state_next = cpu_pkg::S_FETCH1;
        case (ir_mode)
          cpu_pkg::MODE_INH2: begin
            wr_en = 1'b1;
            if (ir_op == cpu_pkg::OP_COM) begin
              wr_data = ~rd_data1;
            end else if (ir_op == cpu_pkg::OP_NEG) begin
              alu_a    = 32'd0;
              alu_b    = rd_data1;
              alu_func = cpu_pkg::ALU_SUB;
            end else begin
              wr_en      = 1'b0;
              state_next = cpu_pkg::S_FAULT;
            end
          end
          cpu_pkg::MODE_IMM2: begin
            if (ir_op == cpu_pkg::OP_LDIS) begin
              wr_data = imm_sext;
              wr_en   = 1'b1;
            end else if (ir_op == cpu_pkg::OP_LDIU) begin
              wr_data = {16'h0000, ir.ext_form.ext};
              wr_en   = 1'b1;
            end else if (ir_op <= cpu_pkg::OP_BRN) begin
              if (taken)
                pc_next = pc + imm_sext; // pc already past second word
            end else begin
              state_next = cpu_pkg::S_FAULT;
            end
          end
          cpu_pkg::MODE_REG: begin
            alu_func = ir_op[3:0];
            wr_en    = 1'b1;
            if (ir_op[7:4] != cpu_pkg::OP_ALU_GROUP) begin
              wr_en      = 1'b0;
              state_next = cpu_pkg::S_FAULT;
            end
          end
          cpu_pkg::MODE_REGIND: begin
            rd_addr2     = ir_ra;
            alu_b        = mar;
            mar_next     = alu_y; // rb + offset
            use_mar_next = 1'b1;
            if (ir_op == cpu_pkg::OP_ST) begin
              mdr_next       = rd_data2;
              write_out_next = 1'b1;
              state_next     = cpu_pkg::S_STORE;
            end else if (ir_op == cpu_pkg::OP_LD) begin
              state_next = cpu_pkg::S_LOAD;
            end else begin
              mar_next     = mar;
              use_mar_next = 1'b0;
              state_next   = cpu_pkg::S_FAULT;
            end
          end
          default: state_next = cpu_pkg::S_FETCH3;
        endcase
      end
      cpu_pkg::S_EVAL3: begin
        state_next = cpu_pkg::S_FETCH1;
        rd_addr2   = ir_ra;
        if (ir_mode == cpu_pkg::MODE_IMM3 && ir_op[7:4] == cpu_pkg::OP_ALU_GROUP) begin
          alu_b    = mdr;
          alu_func = ir_op[3:0];
          wr_en    = 1'b1;
        end else if (ir_mode == cpu_pkg::MODE_IMM3A && ir_op == cpu_pkg::OP_LDI) begin
          wr_data = mdr;
          wr_en   = 1'b1;
        end else if (ir_mode == cpu_pkg::MODE_DIR && ir_op == cpu_pkg::OP_STD) begin
          mdr_next       = rd_data2;
          use_mar_next   = 1'b1;
          write_out_next = 1'b1;
          state_next     = cpu_pkg::S_STORE;
        end else if (ir_mode == cpu_pkg::MODE_DIR && ir_op == cpu_pkg::OP_LDD) begin
          use_mar_next = 1'b1;
          state_next   = cpu_pkg::S_LOAD;
        end else if (ir_mode == cpu_pkg::MODE_DIR && ir_op == cpu_pkg::OP_JMPD) begin
          pc_next = mar;
        end else begin
          state_next = cpu_pkg::S_FAULT;
        end
      end
      cpu_pkg::S_STORE: begin
        write_out_next = 1'b0; // single-cycle strobe
        use_mar_next   = 1'b0;
        state_next     = cpu_pkg::S_FETCH1;
      end
      cpu_pkg::S_LOAD: state_next = cpu_pkg::S_LOAD2;
      cpu_pkg::S_LOAD2: begin
        wr_data      = {16'h0000, data_in};
        wr_en        = 1'b1;
        use_mar_next = 1'b0;
        state_next   = cpu_pkg::S_FETCH1;
      end
      cpu_pkg::S_FAULT: state_next = cpu_pkg::S_FAULT;
      default: state_next = cpu_pkg::S_FAULT;
    endcase
  end

endmodule

//--- logic/cpu_top.sv
module cpu_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] data_in,
  output logic [31:0] addrbus,
  output logic [15:0] data_out,
  output logic        write_out,
  output logic [3:0]  ccr
);

  logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr1, rd_addr2, wr_addr;
  logic [31:0] rd_data1, rd_data2, wr_data;
  logic        wr_en;
  logic [31:0] alu_a, alu_b, alu_y;
  logic [3:0]  alu_func;
  logic        alu_c, alu_n, alu_v, alu_z;

  cpu_sequencer seq (
    .clk(clk), .rst_n(rst_n),
    .data_in(data_in), .addrbus(addrbus), .data_out(data_out),
    .write_out(write_out), .ccr(ccr),
    .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
    .rd_data1(rd_data1), .rd_data2(rd_data2),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .alu_a(alu_a), .alu_b(alu_b), .alu_func(alu_func),
    .alu_y(alu_y), .alu_c(alu_c), .alu_n(alu_n), .alu_v(alu_v), .alu_z(alu_z)
  );

  cpu_alu alu (
    .a(alu_a), .b(alu_b), .func(alu_func),
    .y(alu_y), .c(alu_c), .n(alu_n), .v(alu_v), .z(alu_z)
  );

  register_file regs (
    .clk(clk), .rst_n(rst_n),
    .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
    .rd_data1(rd_data1), .rd_data2(rd_data2),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
  );

endmodule

//--- logic/register_file.sv
module register_file (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr1,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr2,
  output logic [31:0]                    rd_data1,
  output logic [31:0]                    rd_data2,
  input  logic                           wr_en,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] wr_addr,
  input  logic [31:0]                    wr_data
);

  logic [31:0] regs [2**cpu_pkg::REG_ADDR_W];

  assign rd_data1 = regs[rd_addr1]; // no write bypass
  assign rd_data2 = regs[rd_addr2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**cpu_pkg::REG_ADDR_W; i++)
        regs[i] <= 32'h00000000;
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

//--- testbench/cpu_cases.txt
// per case: word count, write count, final ccr; program words; then write address, data pairs
// a zero word count ends the list
// alu ops, constant loads
3B 9 0
E001 1234 5678  A202 00F0  6023 1002  C043 0000 0400  // ldi r1, ldis r2, add r3, std
2024 2000 FFFF  C044 0000 0402  2025 3000 0010  C045 0000 0404  // xor imm, shr imm
0046 1000  C046 0000 0406  0447 1000  C047 0000 0408  // com, neg
8C02  9C48  9008  C048 0000 040A  C042 0000 040C  // inc r2, mov r8, dec r8
A22A 8001  A20B 8001  214C 3000 0010  216D 3000 0010  // ldiu, ldis, upper halves
C04C 0000 040E  C04D 0000 0410  A000 FFFC
400 5768  402 A987  404 1234  406 FF0F  408 FF10  40A 00F0  40C 00F1  40E 0000  410 FFFF
// cmp 5,7 then all twelve branches, then cmp 7fffffff,ffffffff
55 7 E
A201 0005  A202 0007  A203 00B0  8841
A000 0006 C043 0000 0500  A020 0006 C043 0000 0502  A040 0006 C043 0000 0504
A060 0006 C043 0000 0506  A080 0006 C043 0000 0508  A0A0 0006 C043 0000 050A
A0C0 0006 C043 0000 050C  A0E0 0006 C043 0000 050E  A100 0006 C043 0000 0510
A120 0006 C043 0000 0512  A140 0006 C043 0000 0514  A160 0006 C043 0000 0516
E004 7FFF FFFF  A205 FFFF  88A4
A0A0 0006 C043 0000 0518  A0E0 0006 C043 0000 051A  A000 FFFC
502 00B0  506 00B0  508 00B0  50A 00B0  510 00B0  516 00B0  51A 00B0
// st, ld with offsets, std, ldd at a 32-bit address
17 4 0
A201 0400  A222 BEEF  4022 1010  4023 1810  4023 17FE  A224 1234
C044 0002 0600  C065 0002 0600  C045 0002 0602  A000 FFFC
410 BEEF  3FE BEEF  20600 1234  20602 1234
// jmpd over a store
D 1 0
A201 0055  D000 FFC0 0010  C041 0000 0700  C041 0000 0702  A000 FFFC
702 0055
0

//--- testbench/cpu_props.sv
module cpu_props (
  input logic       clk,
  input logic       rst_n,
  input logic       write_out,
  input logic [3:0] state
);

  single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    write_out |=> !write_out)
    else $error("write_out stayed high for two cycles");

  // stores only strobe between eval and S_STORE
  no_write_in_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    (state == cpu_pkg::S_FETCH1 || state == cpu_pkg::S_FETCH2 ||
     state == cpu_pkg::S_FETCH3) |-> !write_out)
    else $error("write_out high in a fetch state");

  fault_sticks: assert property (@(posedge clk) disable iff (!rst_n)
    state == cpu_pkg::S_FAULT |=> state == cpu_pkg::S_FAULT)
    else $error("sequencer left the fault state");

endmodule

bind cpu_sequencer cpu_props props (
  .clk(clk), .rst_n(rst_n), .write_out(write_out), .state(state)
);

//--- testbench/cpu_tb.sv
module cpu_tb;

  logic        clk;
  logic        rst_n;
  logic [15:0] data_in = 16'h0000;
  logic [31:0] addrbus;
  logic [15:0] data_out;
  logic        write_out;
  logic [3:0]  ccr;

  logic [31:0] cases_mem [0:2047];
  logic [15:0] mem [0:1023];
  logic [31:0] exp_addr [0:63];
  logic [15:0] exp_data [0:63];
  logic [3:0]  exp_ccr;
  int          prog_base;
  int          prog_len;
  int          n_exp;
  int          n_seen = 0;
  int          value_errors;
  int          other_errors;
  int          limit_cycles;

  cpu_top dut (
    .clk(clk), .rst_n(rst_n), .data_in(data_in), .addrbus(addrbus),
    .data_out(data_out), .write_out(write_out), .ccr(ccr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // memory model, program image reloaded while reset is low
  always @(clk) begin
    if (!clk) begin
      if (!rst_n) begin
        for (int i = 0; i < 1024; i++)
          mem[i] = (i < prog_len) ? cases_mem[prog_base + i][15:0] : (16'(i) ^ 16'hc3a5);
        n_seen = 0;
      end
      data_in <= mem[addrbus[10:1]];
    end else if (rst_n && write_out) begin
      mem[addrbus[10:1]] = data_out;
      if (n_seen < n_exp) begin
        check("addrbus", addrbus, exp_addr[n_seen]);
        check("data_out", {16'h0000, data_out}, {16'h0000, exp_data[n_seen]});
      end else begin
        other_errors++;
        $display("unexpected write of %h to address %h", data_out, addrbus);
      end
      n_seen = n_seen + 1;
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("run timed out after %0d cycles", limit_cycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    int p;
    int words;
    int n_cases;
    int total_words;
    int k;
    rst_n = 1'b0;
    prog_base = 0;
    prog_len = 0;
    n_exp = 0;
    for (int i = 0; i < 2048; i++)
      cases_mem[i] = 32'h0;
    $readmemh("testbench/cpu_cases.txt", cases_mem);
    p = 0;
    n_cases = 0;
    total_words = 0;
    while (cases_mem[p] != 32'h0) begin // header: words, writes, ccr
      total_words += int'(cases_mem[p]);
      n_cases++;
      p += 3 + int'(cases_mem[p]) + 2 * int'(cases_mem[p + 1]);
    end
    if (n_cases == 0) begin
      other_errors++;
      $display("no cases found in the case file");
    end
    limit_cycles = 40 * total_words + 30 * n_cases;
    p = 0;
    for (int c = 0; c < n_cases; c++) begin
      @(negedge clk);
      rst_n = 1'b0;
      words = int'(cases_mem[p]);
      n_exp = int'(cases_mem[p + 1]);
      exp_ccr = cases_mem[p + 2][3:0];
      prog_base = p + 3;
      prog_len = words;
      for (int w = 0; w < n_exp; w++) begin
        exp_addr[w] = cases_mem[p + 3 + words + 2 * w];
        exp_data[w] = cases_mem[p + 4 + words + 2 * w][15:0];
      end
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      k = 0;
      while (n_seen < n_exp && k < 40 * words) begin
        @(negedge clk);
        k++;
      end
      if (n_seen < n_exp) begin
        other_errors++;
        $display("case %0d: only %0d of %0d expected writes seen", c, n_seen, n_exp);
      end
      repeat (20) @(negedge clk); // let late strays show up
      check("ccr", {28'h0, ccr}, {28'h0, exp_ccr});
      p += 3 + words + 2 * n_exp;
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
